/* design/icache_pkg.sv */
package icache_pkg;

   //////////////////////////////////////////////////
   // Line geometry
   //////////////////////////////////////////////////

   // Beats per refill burst, one word each
   localparam int LINE_WORDS = 8;

   //////////////////////////////////////////////////
   // Address and data types
   //////////////////////////////////////////////////

   typedef logic [31:0] addr_t;
   typedef logic [31:0] word_t;

   // Address fields: tag 31..12, index 11..5, offset 4..2
   typedef logic [19:0] tag_t;
   typedef logic [6:0]  index_t;
   typedef logic [2:0]  offset_t;

   // Word k sits in bits [32*k +: 32]
   typedef logic [LINE_WORDS*32-1:0] line_t;

   // Way number, also one LRU entry
   typedef logic way_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_ADDR,
      ST_REFILL,
      ST_WRITE
   } ctrl_state_t;

endpackage

/* design/icache_tag_store.sv */
`timescale 1ns/1ns

module icache_tag_store (
   input  logic               clk,
   input  logic               reset,
   input  icache_pkg::index_t i_rd_index,
   input  icache_pkg::tag_t   i_lookup_tag,
   input  logic               i_lookup,
   input  logic               i_wr,
   input  icache_pkg::index_t i_wr_index,
   input  icache_pkg::tag_t   i_wr_tag,
   output logic               o_hit,
   output icache_pkg::way_t   o_hit_way,
   output icache_pkg::way_t   o_victim_way
);
   import icache_pkg::*;

   localparam int NUM_SETS = 1 << $bits(index_t);

   tag_t                tag_mem [2][NUM_SETS];
   tag_t                tag_rd [2];
   logic [NUM_SETS-1:0] valid [2];
   logic [NUM_SETS-1:0] lru;
   index_t              rd_index_q;
   way_t                victim_q;
   logic [1:0]          way_match;

   // Tag memories, synchronous read
   always_ff @(posedge clk) begin
      for (int w = 0; w < 2; w++) begin
         tag_rd[w] <= tag_mem[w][i_rd_index];
      end
      rd_index_q <= i_rd_index;
      if (i_wr) begin
         tag_mem[victim_q][i_wr_index] <= i_wr_tag;
      end
   end

   // Compare both ways in the lookup cycle
   always_comb begin
      for (int w = 0; w < 2; w++) begin
         way_match[w] = valid[w][rd_index_q] && (tag_rd[w] == i_lookup_tag);
      end
   end

   assign o_hit     = i_lookup & (|way_match);
   assign o_hit_way = way_match[1];

   // Valid and LRU bits; LRU points at the way to replace next
   always_ff @(posedge clk) begin
      if (reset) begin
         valid[0] <= '0;
         valid[1] <= '0;
         lru      <= '0;
         victim_q <= 1'b0;
      end else begin
         if (i_lookup) begin
            if (o_hit) begin
               lru[rd_index_q] <= ~o_hit_way;
            end else begin
               victim_q <= lru[rd_index_q];
            end
         end
         if (i_wr) begin
            valid[victim_q][i_wr_index] <= 1'b1;
            lru[i_wr_index]             <= ~victim_q;
         end
      end
   end

   assign o_victim_way = victim_q;

endmodule

/* design/icache_data_store.sv */
`timescale 1ns/1ns

module icache_data_store (
   input  logic                clk,
   input  icache_pkg::index_t  i_rd_index,
   input  icache_pkg::offset_t i_rd_offset,
   input  icache_pkg::way_t    i_hit_way,
   input  logic                i_wr,
   input  icache_pkg::way_t    i_wr_way,
   input  icache_pkg::index_t  i_wr_index,
   input  icache_pkg::line_t   i_wr_line,
   output icache_pkg::word_t   o_rddata
);
   import icache_pkg::*;

   localparam int NUM_SETS  = 1 << $bits(index_t);
   localparam int WORD_BITS = $bits(word_t);

   line_t   rd_line [2];
   offset_t rd_offset_q;

   //////////////////////////////////////////////////
   // One line-wide memory per way
   //////////////////////////////////////////////////
   for (genvar w = 0; w < 2; w++) begin : g_way
      line_t mem [NUM_SETS];

      always_ff @(posedge clk) begin
         // Whole line goes in at once after refill
         if (i_wr && (i_wr_way == way_t'(w))) begin
            mem[i_wr_index] <= i_wr_line;
         end
         rd_line[w] <= mem[i_rd_index];
      end
   end

   // Offset travels with the read so the word select lines up
   always_ff @(posedge clk) begin
      rd_offset_q <= i_rd_offset;
   end

   // Way from the tag compare, then word from the line
   assign o_rddata = rd_line[i_hit_way][rd_offset_q*WORD_BITS +: WORD_BITS];

endmodule

/* design/icache_fill_buffer.sv */
`timescale 1ns/1ns

module icache_fill_buffer (
   input  logic                clk,
   input  logic                reset,
   input  logic                i_start,
   input  icache_pkg::offset_t i_start_offset,
   input  icache_pkg::word_t   i_rdata,
   input  logic                i_rvalid,
   input  logic                i_rlast,
   output icache_pkg::line_t   o_line,
   output logic                o_crit_valid,
   output icache_pkg::word_t   o_crit_word,
   output logic                o_done
);
   import icache_pkg::*;

   localparam int WORD_BITS = $bits(word_t);

   offset_t beat_cnt;
   logic    active;
   logic    crit_pending;
   logic    beat;
   line_t   line_q;

   // Beats only count between start and the last beat
   assign beat = active & i_rvalid;

   //////////////////////////////////////////////////
   // Wrapping beat counter and status
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         beat_cnt     <= '0;
         active       <= 1'b0;
         crit_pending <= 1'b0;
         o_crit_valid <= 1'b0;
         o_done       <= 1'b0;
      end else begin
         o_crit_valid <= beat & crit_pending;
         o_done       <= beat & i_rlast;
         if (i_start) begin
            beat_cnt     <= i_start_offset;
            active       <= 1'b1;
            crit_pending <= 1'b1;
         end else if (beat) begin
            beat_cnt     <= beat_cnt + 3'd1;  // wraps modulo eight
            crit_pending <= 1'b0;
            if (i_rlast) begin
               active <= 1'b0;
            end
         end
      end
   end

   // Line assembly; first beat is the critical word
   always_ff @(posedge clk) begin
      if (beat) begin
         line_q[beat_cnt*WORD_BITS +: WORD_BITS] <= i_rdata;
         if (crit_pending) begin
            o_crit_word <= i_rdata;
         end
      end
   end

   assign o_line = line_q;

endmodule

/* design/icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl (
   input  logic                clk,
   input  logic                reset,
   // Processor request
   input  logic                i_read,
   input  icache_pkg::addr_t   i_addr,
   // From the stores and fill buffer
   input  logic                i_hit,
   input  icache_pkg::word_t   i_store_rddata,
   input  logic                i_crit_valid,
   input  icache_pkg::word_t   i_crit_word,
   input  logic                i_fill_done,
   input  logic                i_arready,
   // Store lookup
   output icache_pkg::index_t  o_rd_index,
   output icache_pkg::offset_t o_rd_offset,
   output logic                o_lookup,
   output icache_pkg::tag_t    o_lookup_tag,
   // Refill control
   output logic                o_fill_start,
   output icache_pkg::offset_t o_fill_offset,
   output logic                o_line_wr,
   output icache_pkg::index_t  o_wr_index,
   // Processor response
   output icache_pkg::word_t   o_rddata,
   output logic                o_valid,
   output logic                o_busy,
   // Burst read request
   output icache_pkg::addr_t   o_araddr,
   output logic                o_arvalid
);
   import icache_pkg::*;

   ctrl_state_t state;
   addr_t       addr_q;
   logic        idle;

   assign idle = (state == ST_IDLE);

   // Request address, held for the whole transaction
   always_ff @(posedge clk) begin
      if (idle && i_read) begin
         addr_q <= i_addr;
      end
   end

   //////////////////////////////////////////////////
   // Lookup / refill FSM
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_read) begin
                  state <= ST_LOOKUP;
               end
            end
            ST_LOOKUP: begin
               state <= i_hit ? ST_IDLE : ST_ADDR;
            end
            ST_ADDR: begin
               if (i_arready) begin
                  state <= ST_REFILL;
               end
            end
            ST_REFILL: begin
               if (i_fill_done) begin
                  state <= ST_WRITE;
               end
            end
            ST_WRITE: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Stores read from the incoming address while idle
   assign o_rd_index   = idle ? i_addr[11:5] : addr_q[11:5];
   assign o_rd_offset  = idle ? i_addr[4:2] : addr_q[4:2];
   assign o_lookup     = (state == ST_LOOKUP);
   assign o_lookup_tag = addr_q[31:12];

   // Fill buffer is armed on the miss, before the burst goes out
   assign o_fill_start  = o_lookup & ~i_hit;
   assign o_fill_offset = addr_q[4:2];
   assign o_line_wr     = (state == ST_WRITE);
   assign o_wr_index    = addr_q[11:5];

   // Critical word first
   assign o_araddr  = {addr_q[31:2], 2'b00};
   assign o_arvalid = (state == ST_ADDR);

   assign o_valid  = (o_lookup & i_hit) | ((state == ST_REFILL) & i_crit_valid);
   assign o_rddata = (state == ST_REFILL) ? i_crit_word : i_store_rddata;
   assign o_busy   = ~idle;

endmodule

/* design/icache_top.sv */
`timescale 1ns/1ns

module icache_top (
   input  logic              clk,
   input  logic              reset,
   // Processor side
   input  logic              i_read,
   input  icache_pkg::addr_t i_addr,
   output icache_pkg::word_t o_rddata,
   output logic              o_valid,
   output logic              o_busy,
   // Memory side
   output icache_pkg::addr_t o_araddr,
   output logic              o_arvalid,
   input  logic              i_arready,
   input  icache_pkg::word_t i_rdata,
   input  logic              i_rvalid,
   input  logic              i_rlast
);
   import icache_pkg::*;

   index_t  rd_index;
   offset_t rd_offset;
   logic    lookup;
   tag_t    lookup_tag;
   logic    hit;
   way_t    hit_way;
   way_t    victim_way;
   word_t   store_rddata;
   logic    fill_start;
   offset_t fill_offset;
   line_t   fill_line;
   logic    crit_valid;
   word_t   crit_word;
   logic    fill_done;
   logic    line_wr;
   index_t  wr_index;

   //////////////////////////////////////////////////
   // Controller
   //////////////////////////////////////////////////
   icache_ctrl u_ctrl (
      .clk            (clk),
      .reset          (reset),
      .i_read         (i_read),
      .i_addr         (i_addr),
      .i_hit          (hit),
      .i_store_rddata (store_rddata),
      .i_crit_valid   (crit_valid),
      .i_crit_word    (crit_word),
      .i_fill_done    (fill_done),
      .i_arready      (i_arready),
      .o_rd_index     (rd_index),
      .o_rd_offset    (rd_offset),
      .o_lookup       (lookup),
      .o_lookup_tag   (lookup_tag),
      .o_fill_start   (fill_start),
      .o_fill_offset  (fill_offset),
      .o_line_wr      (line_wr),
      .o_wr_index     (wr_index),
      .o_rddata       (o_rddata),
      .o_valid        (o_valid),
      .o_busy         (o_busy),
      .o_araddr       (o_araddr),
      .o_arvalid      (o_arvalid)
   );

   //////////////////////////////////////////////////
   // Stores and fill buffer
   //////////////////////////////////////////////////

   // Refill tag is the held request tag
   icache_tag_store u_tag_store (
      .clk          (clk),
      .reset        (reset),
      .i_rd_index   (rd_index),
      .i_lookup_tag (lookup_tag),
      .i_lookup     (lookup),
      .i_wr         (line_wr),
      .i_wr_index   (wr_index),
      .i_wr_tag     (lookup_tag),
      .o_hit        (hit),
      .o_hit_way    (hit_way),
      .o_victim_way (victim_way)
   );

   icache_data_store u_data_store (
      .clk         (clk),
      .i_rd_index  (rd_index),
      .i_rd_offset (rd_offset),
      .i_hit_way   (hit_way),
      .i_wr        (line_wr),
      .i_wr_way    (victim_way),
      .i_wr_index  (wr_index),
      .i_wr_line   (fill_line),
      .o_rddata    (store_rddata)
   );

   icache_fill_buffer u_fill_buffer (
      .clk            (clk),
      .reset          (reset),
      .i_start        (fill_start),
      .i_start_offset (fill_offset),
      .i_rdata        (i_rdata),
      .i_rvalid       (i_rvalid),
      .i_rlast        (i_rlast),
      .o_line         (fill_line),
      .o_crit_valid   (crit_valid),
      .o_crit_word    (crit_word),
      .o_done         (fill_done)
   );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
   input  logic i_reset_req,
   output logic clk,
   output logic reset
);
   localparam int RESET_CYCLES = 10;

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset at power-up, and again whenever a reset is requested
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      forever begin
         @(posedge clk);
         if (i_reset_req) begin
            reset <= 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
         end
      end
   end

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;
   import icache_pkg::*;

   localparam int VALID_WAIT     = 64;
   // 16 misses of up to 40 cycles, 27 hits and two resets
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        reset;
   logic        reset_req;
   logic        i_read;
   addr_t       i_addr;
   logic        i_arready;
   word_t       i_rdata;
   logic        i_rvalid;
   logic        i_rlast;
   word_t       o_rddata;
   logic        o_valid;
   logic        o_busy;
   addr_t       o_araddr;
   logic        o_arvalid;
   int          error_count  = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          burst_count  = 0;
   int          cycle_count  = 0;
   addr_t       last_araddr;
   logic [31:0] rand_state   = 32'hc5d3;

   tb_clock_gen clock_gen (
      .i_reset_req (reset_req),
      .clk         (clk),
      .reset       (reset)
   );

   icache_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .i_read    (i_read),
      .i_addr    (i_addr),
      .o_rddata  (o_rddata),
      .o_valid   (o_valid),
      .o_busy    (o_busy),
      .o_araddr  (o_araddr),
      .o_arvalid (o_arvalid),
      .i_arready (i_arready),
      .i_rdata   (i_rdata),
      .i_rvalid  (i_rvalid),
      .i_rlast   (i_rlast)
   );

   // Fixed word pattern of the word address
   function automatic word_t mem_word(input addr_t addr);
      logic [31:0] x;
      x = {addr[31:2], 2'b00} ^ 32'h9e37_79b9;
      x = x * 32'h85eb_ca6b;
      return x ^ (x >> 15);
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
         error_count++;
      end
   endtask

   //////////////////////////////////////////////////
   // Memory model serving wrapping bursts with random stalls
   //////////////////////////////////////////////////
   task automatic serve_burst();
      addr_t   req_addr;
      offset_t beat_off;
      int      delay;
      int      gap;
      req_addr    = o_araddr;
      last_araddr = req_addr;
      burst_count++;
      rand_state = lcg_next(rand_state);
      delay      = rand_state[17:16];
      // Request has to hold while ready is low
      repeat (delay) begin
         @(posedge clk);
         @(negedge clk);
         check_value("o_arvalid", o_arvalid, 1'b1);
         check_value("o_araddr", o_araddr, req_addr);
      end
      @(posedge clk);
      i_arready <= 1'b1;
      @(negedge clk);
      check_value("o_arvalid", o_arvalid, 1'b1);
      check_value("o_araddr", o_araddr, req_addr);
      @(posedge clk);
      i_arready <= 1'b0;
      beat_off = req_addr[4:2];
      for (int k = 0; k < LINE_WORDS; k++) begin
         rand_state = lcg_next(rand_state);
         gap        = rand_state[17:16] % 3;
         if (gap != 0) begin
            i_rvalid <= 1'b0;
            i_rlast  <= 1'b0;
            repeat (gap) @(posedge clk);
         end
         i_rvalid <= 1'b1;
         i_rdata  <= mem_word({req_addr[31:5], beat_off, 2'b00});
         i_rlast  <= (k == LINE_WORDS - 1);
         beat_off = beat_off + 3'd1;
         @(posedge clk);
      end
      i_rvalid <= 1'b0;
      i_rlast  <= 1'b0;
   endtask

   initial begin
      i_arready = 1'b0;
      i_rdata   = '0;
      i_rvalid  = 1'b0;
      i_rlast   = 1'b0;
      forever begin
         @(negedge clk);
         if (!reset && o_arvalid) begin
            serve_burst();
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Processor side
   //////////////////////////////////////////////////

   // Latency counts cycles from the sampling edge to o_valid
   task automatic issue_read(input addr_t addr, output word_t data, output int latency);
      int waited;
      int extra;
      check_value("o_busy", o_busy, 1'b0);
      @(posedge clk);
      i_read <= 1'b1;
      i_addr <= addr;
      @(posedge clk);
      i_read <= 1'b0;
      @(negedge clk);
      check_value("o_busy", o_busy, 1'b1);
      waited = 1;
      while (!o_valid && waited < VALID_WAIT) begin
         @(negedge clk);
         waited++;
      end
      latency = waited;
      data    = o_rddata;
      if (!o_valid) begin
         $display("No o_valid within %0d cycles of the read at %h", VALID_WAIT, addr);
         error_count++;
      end
      // Only one response per request, up to and including the first idle cycle
      extra  = 0;
      waited = 0;
      @(negedge clk);
      if (o_valid) begin
         extra++;
      end
      while (o_busy && waited < VALID_WAIT) begin
         @(negedge clk);
         waited++;
         if (o_valid) begin
            extra++;
         end
      end
      check_value("o_valid extra pulses", extra, 0);
      if (o_busy) begin
         $display("Cache still busy long after the read at %h", addr);
         error_count++;
      end
   endtask

   task automatic verify_read(input addr_t addr, input logic expect_miss);
      word_t data;
      int    latency;
      int    bursts_before;
      bursts_before = burst_count;
      issue_read(addr, data, latency);
      check_value("o_rddata", data, mem_word(addr));
      check_value("burst requests", burst_count - bursts_before, expect_miss);
      if (expect_miss) begin
         check_value("o_araddr", last_araddr, {addr[31:2], 2'b00});
      end else begin
         check_value("hit latency", latency, 1);
      end
   endtask

   task automatic await_reset_release();
      @(negedge clk);
      while (reset) begin
         @(negedge clk);
      end
      check_value("o_arvalid", o_arvalid, 1'b0);
      check_value("o_valid", o_valid, 1'b0);
      check_value("o_busy", o_busy, 1'b0);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset_req <= 1'b1;
      @(posedge clk);
      reset_req <= 1'b0;
      await_reset_release();
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (error_count == errors_before) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, error_count - errors_before);
      end
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic cold_miss();
      int errors_before;
      errors_before = error_count;
      verify_read(32'h0000_1234, 1'b1);
      report_test("cold_miss", errors_before);
   endtask

   task automatic line_hits();
      int errors_before;
      errors_before = error_count;
      for (int k = 0; k < LINE_WORDS; k++) begin
         verify_read(32'h0000_1220 + 4 * k, 1'b0);
      end
      report_test("line_hits", errors_before);
   endtask

   // Set 0x40 with tags 0x20 and 0x30
   task automatic both_ways();
      int errors_before;
      errors_before = error_count;
      verify_read(32'h0002_0800, 1'b1);
      verify_read(32'h0003_0804, 1'b1);
      for (int k = 0; k < 4; k++) begin
         verify_read(32'h0002_0800 + 8 * k, 1'b0);
         verify_read(32'h0003_0804 + 8 * k, 1'b0);
      end
      report_test("both_ways", errors_before);
   endtask

   // Lines A, B and C all map to set 0x22
   task automatic lru_replacement();
      int errors_before;
      errors_before = error_count;
      verify_read(32'h0004_0440, 1'b1);
      verify_read(32'h0005_0440, 1'b1);
      verify_read(32'h0004_0444, 1'b0);
      verify_read(32'h0006_0448, 1'b1);
      verify_read(32'h0004_044c, 1'b0);
      verify_read(32'h0005_0450, 1'b1);
      report_test("lru_replacement", errors_before);
   endtask

   // Every critical offset, then a hit elsewhere in the wrapped line
   task automatic back_pressure();
      int    errors_before;
      addr_t line_addr;
      errors_before = error_count;
      for (int k = 0; k < LINE_WORDS; k++) begin
         line_addr = 32'h0007_0000 + (32'h50 + k) * 32;
         verify_read(line_addr + 4 * k, 1'b1);
         verify_read(line_addr + 4 * ((k + 3) % LINE_WORDS), 1'b0);
      end
      report_test("back_pressure", errors_before);
   endtask

   task automatic reset_clears();
      int errors_before;
      errors_before = error_count;
      verify_read(32'h0000_1234, 1'b0);
      apply_reset();
      verify_read(32'h0000_1234, 1'b1);
      report_test("reset_clears", errors_before);
   endtask

   initial begin
      i_read    = 1'b0;
      i_addr    = '0;
      reset_req = 1'b0;
      await_reset_release();
      cold_miss();
      line_hits();
      both_ways();
      lru_replacement();
      back_pressure();
      reset_clears();
      $display("Summary: %0d tests, %0d failed, %0d errors",
               tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("FAIL: see errors above");
         $finish;
      end
   end

endmodule

/* build.f */
design/icache_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_fill_buffer.sv
design/icache_ctrl.sv
design/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/icache_tag_store.sv
  - design/icache_data_store.sv
  - design/icache_fill_buffer.sv
  - design/icache_ctrl.sv
  - design/icache_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/icache_tb.sv
